// ==== run.sh ====
#!/bin/sh
# Build and run the CSR file testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_csr_file -f tb.f -o sim_tb \
  || { echo "build failed"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

grep -q "TB FAILED" sim.log && exit 1 || grep -q "TB PASSED" sim.log || exit 1
exit 0

// ==== src/csr_access_decode.sv ====
// CSR access decoder: operation merge, privilege and read-only check, write strobes
`include "csr_settings.svh"

module csr_access_decode
  import csr_addr_pkg::*;
  import csr_fields_pkg::*;
(
  input  csr_addr_t   csr_addr,
  input  logic        csr_write,
  input  logic        csr_set,
  input  logic        csr_clear,
  input  logic        csr_read_only,
  input  logic        valid_write,
  input  csr_word_t   new_csr_val,
  input  priv_level_t curr_privilege_level,
  input  csr_word_t   old_csr_val,
  output csr_view_u   merged_val,
  output logic        invalid_priv,
  output logic        we_mstatus,
  output logic        we_mtvec,
  output logic        we_mie,
  output logic        we_mip,
  output logic        we_mscratch,
  output logic        we_mepc,
  output logic        we_mcause,
  output logic        we_mtval,
  output logic        we_mcounteren,
  output logic        we_mcountinhibit,
  csr_counter_if.ctl  cnt_ifs [`CSR_NUM_COUNTERS]
);

  logic csr_op;
  logic ro_violation;
  logic priv_violation;
  logic wr_ok;

  assign csr_op = csr_write | csr_set | csr_clear;

  always_comb begin
    if (csr_set) begin
      merged_val.word = old_csr_val | new_csr_val;
    end else if (csr_clear) begin
      merged_val.word = old_csr_val & ~new_csr_val;
    end else begin
      merged_val.word = new_csr_val;    // Plain write
    end
  end

  // Top address bits 11 mark a read-only CSR
  assign ro_violation   = (csr_addr[11:10] == 2'b11) && !csr_read_only;
  assign priv_violation = csr_addr[9:8] > curr_privilege_level;
  assign invalid_priv   = csr_op & (ro_violation | priv_violation);

  assign wr_ok = valid_write & csr_op & ~csr_read_only & ~ro_violation & ~priv_violation;

  assign we_mstatus       = wr_ok && (csr_addr == MSTATUS_ADDR);
  assign we_mtvec         = wr_ok && (csr_addr == MTVEC_ADDR);
  assign we_mie           = wr_ok && (csr_addr == MIE_ADDR);
  assign we_mip           = wr_ok && (csr_addr == MIP_ADDR);
  assign we_mscratch      = wr_ok && (csr_addr == MSCRATCH_ADDR);
  assign we_mepc          = wr_ok && (csr_addr == MEPC_ADDR);
  assign we_mcause        = wr_ok && (csr_addr == MCAUSE_ADDR);
  assign we_mtval         = wr_ok && (csr_addr == MTVAL_ADDR);
  assign we_mcounteren    = wr_ok && (csr_addr == MCOUNTEREN_ADDR);
  assign we_mcountinhibit = wr_ok && (csr_addr == MCOUNTINHIBIT_ADDR);

  // Counter half writes, machine addresses only
  for (genvar i = 0; i < `CSR_NUM_COUNTERS; i++) begin : g_cnt_wr
    assign cnt_ifs[i].wr_lo = wr_ok && (csr_addr == CNT_SLOT_LO_ADDR[i]);
    assign cnt_ifs[i].wr_hi = wr_ok && (csr_addr == CNT_SLOT_HI_ADDR[i]);
    assign cnt_ifs[i].wdata = merged_val.word;
  end

  // The pipeline issues one CSR operation per instruction
  always_comb begin
    assert final ($onehot0({csr_write, csr_set, csr_clear}))
      else $error("csr_access_decode: several CSR operations at once");
  end

endmodule

// ==== src/csr_addr_pkg.sv ====
// CSR address constants, privilege level type and counter slot tables
`include "csr_settings.svh"

package csr_addr_pkg;

  typedef logic [11:0] csr_addr_t;

  typedef enum logic [1:0] {
    U_MODE        = 2'b00,
    S_MODE        = 2'b01,
    RESERVED_MODE = 2'b10,
    M_MODE        = 2'b11
  } priv_level_t;

  typedef logic [1:0] cnt_slot_t;

  // Machine information, all read-only
  localparam csr_addr_t MVENDORID_ADDR  = 12'hF11;
  localparam csr_addr_t MARCHID_ADDR    = 12'hF12;
  localparam csr_addr_t MIMPID_ADDR     = 12'hF13;
  localparam csr_addr_t MHARTID_ADDR    = 12'hF14;
  localparam csr_addr_t MCONFIGPTR_ADDR = 12'hF15;

  // Machine trap setup and handling
  localparam csr_addr_t MSTATUS_ADDR       = 12'h300;
  localparam csr_addr_t MISA_ADDR          = 12'h301;
  localparam csr_addr_t MIE_ADDR           = 12'h304;
  localparam csr_addr_t MTVEC_ADDR         = 12'h305;
  localparam csr_addr_t MCOUNTEREN_ADDR    = 12'h306;
  localparam csr_addr_t MSTATUSH_ADDR      = 12'h310;
  localparam csr_addr_t MCOUNTINHIBIT_ADDR = 12'h320;
  localparam csr_addr_t MSCRATCH_ADDR      = 12'h340;
  localparam csr_addr_t MEPC_ADDR          = 12'h341;
  localparam csr_addr_t MCAUSE_ADDR        = 12'h342;
  localparam csr_addr_t MTVAL_ADDR         = 12'h343;
  localparam csr_addr_t MIP_ADDR           = 12'h344;

  // User time view of external mtime
  localparam csr_addr_t TIME_ADDR  = 12'hC01;
  localparam csr_addr_t TIMEH_ADDR = 12'hC81;
  localparam int        TIME_BIT   = 1;     // mcounteren.tm

  // User counter view sits 0x100 above the machine one
  localparam csr_addr_t USER_CNT_OFFSET = 12'h100;

  // Slot order: cycle, instret, hpm3, hpm4
  localparam int CNT_SLOT_BIT [`CSR_NUM_COUNTERS] = '{0, 2, 3, 4};
  localparam csr_addr_t CNT_SLOT_LO_ADDR [`CSR_NUM_COUNTERS] =
    '{12'hB00, 12'hB02, 12'hB03, 12'hB04};
  localparam csr_addr_t CNT_SLOT_HI_ADDR [`CSR_NUM_COUNTERS] =
    '{12'hB80, 12'hB82, 12'hB83, 12'hB84};

endpackage

// ==== src/csr_counter.sv ====
// One 64-bit performance counter with inhibit, increment and half-word writes
`include "csr_settings.svh"

module csr_counter (
  input logic        CLK,
  input logic        nRST,
  csr_counter_if.cnt cif
);

  localparam int HALF = `CSR_XLEN;

  logic [`CSR_CNT_WIDTH-1:0] count;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      count <= '0;
    end else if (cif.wr_lo) begin
      count <= {count[`CSR_CNT_WIDTH-1:HALF], cif.wdata};  // Upper half kept
    end else if (cif.wr_hi) begin
      count <= {cif.wdata, count[HALF-1:0]};
    end else if (!cif.inhibit) begin
      count <= count + `CSR_CNT_WIDTH'(cif.inc);
    end
  end

  assign cif.value = count;

  // Decoder maps each address to one half only
  a_one_half: assert property (@(posedge CLK) disable iff (!nRST)
    !(cif.wr_lo && cif.wr_hi))
    else $error("csr_counter: both halves written in one cycle");

endmodule

// ==== src/csr_counter_if.sv ====
// Interface for one performance counter slot: write strobes, increment, inhibit, value
`include "csr_settings.svh"

interface csr_counter_if;
  logic                       wr_lo;    // Write low half
  logic                       wr_hi;    // Write high half
  logic [`CSR_XLEN-1:0]       wdata;
  logic                       inhibit;  // From mcountinhibit
  logic                       inc;      // Event this cycle
  logic [`CSR_CNT_WIDTH-1:0]  value;

  modport ctl (output wr_lo, wr_hi, wdata);
  modport cfg (output inhibit);
  modport src (output inc);
  modport cnt (input wr_lo, wr_hi, wdata, inhibit, inc, output value);
  modport rd  (input value);
endinterface

// ==== src/csr_fields_pkg.sv ====
// Register field layouts, misa constant and the union that views a CSR data word
`include "csr_settings.svh"

package csr_fields_pkg;
  import csr_addr_pkg::*;

  typedef logic [`CSR_XLEN-1:0] csr_word_t;

  typedef enum logic [1:0] {
    DIRECT   = 2'b00,
    VECTORED = 2'b01
  } vector_mode_t;

  // Only M and U fields are live, S bits fold into reserved
  typedef struct packed {
    logic        sd;
    logic [8:0]  reserved_3;
    logic        tw;
    logic [2:0]  reserved_2;
    logic        mprv;
    logic [1:0]  xs;
    logic [1:0]  fs;
    priv_level_t mpp;
    logic [1:0]  vs;
    logic        reserved_1;
    logic        mpie;
    logic [2:0]  reserved_0b;
    logic        mie;
    logic [2:0]  reserved_0a;
  } mstatus_t;

  typedef struct packed {
    logic [29:0]  base;
    vector_mode_t mode;
  } mtvec_t;

  // Shared by mie and mip
  typedef struct packed {
    logic [19:0] reserved_hi;
    logic        meie;
    logic        reserved_10;
    logic        seie;
    logic        reserved_8;
    logic        mtie;
    logic        reserved_6;
    logic        stie;
    logic        reserved_4;
    logic        msie;
    logic        reserved_2;
    logic        ssie;
    logic        reserved_0;
  } mint_t;

  typedef struct packed {
    logic        interrupt;
    logic [30:0] cause;
  } mcause_t;

  // One merged write word, decoded by the addressed register
  typedef union packed {
    csr_word_t word;
    mstatus_t  mstatus;
    mtvec_t    mtvec;
    mint_t     mint;
    mcause_t   mcause;
  } csr_view_u;

  localparam csr_word_t MISA_RV32IU = 32'h4010_0100;   // MXL=1, U and I

endpackage

// ==== src/csr_file.sv ====
// Machine-mode CSR file top: access decode, trap registers, counters and read mux
`include "csr_settings.svh"

module csr_file
  import csr_addr_pkg::*;
  import csr_fields_pkg::*;
(
  input  logic                         CLK,
  input  logic                         nRST,
  input  logic [`CSR_CNT_WIDTH-1:0]    mtime,
  input  csr_addr_t                    csr_addr,
  input  logic                         csr_write,
  input  logic                         csr_set,
  input  logic                         csr_clear,
  input  logic                         csr_read_only,
  input  logic                         valid_write,
  input  csr_word_t                    new_csr_val,
  input  priv_level_t                  curr_privilege_level,
  input  logic                         inst_ret,
  input  logic [`CSR_NUM_COUNTERS-3:0] hpm_inc,
  input  logic                         inject_mstatus,
  input  mstatus_t                     next_mstatus,
  input  logic                         inject_mepc,
  input  csr_word_t                    next_mepc,
  input  logic                         inject_mcause,
  input  mcause_t                      next_mcause,
  input  logic                         inject_mtval,
  input  csr_word_t                    next_mtval,
  input  logic                         inject_mip,
  input  mint_t                        next_mip,
  output csr_word_t                    old_csr_val,
  output logic                         invalid_csr,
  output mstatus_t                     curr_mstatus,
  output mtvec_t                       curr_mtvec,
  output mint_t                        curr_mie,
  output mint_t                        curr_mip,
  output csr_word_t                    curr_mepc,
  output mcause_t                      curr_mcause
);

  csr_view_u merged_val;
  logic      invalid_priv;
  logic      invalid_addr;
  logic      we_mstatus;
  logic      we_mtvec;
  logic      we_mie;
  logic      we_mip;
  logic      we_mscratch;
  logic      we_mepc;
  logic      we_mcause;
  logic      we_mtval;
  logic      we_mcounteren;
  logic      we_mcountinhibit;
  csr_word_t mscratch;
  csr_word_t mtval;
  csr_word_t mcounteren;
  csr_word_t mcountinhibit;

  csr_counter_if cnt_ifs [`CSR_NUM_COUNTERS] ();

  csr_access_decode u_decode (
    .csr_addr, .csr_write, .csr_set, .csr_clear, .csr_read_only, .valid_write,
    .new_csr_val, .curr_privilege_level, .old_csr_val, .merged_val, .invalid_priv,
    .we_mstatus, .we_mtvec, .we_mie, .we_mip, .we_mscratch, .we_mepc, .we_mcause,
    .we_mtval, .we_mcounteren, .we_mcountinhibit, .cnt_ifs(cnt_ifs)
  );

  csr_trap_regs u_trap_regs (
    .CLK, .nRST, .merged_val, .new_csr_val,
    .we_mstatus, .we_mtvec, .we_mie, .we_mip, .we_mscratch, .we_mepc, .we_mcause,
    .we_mtval, .we_mcounteren, .we_mcountinhibit,
    .inject_mstatus, .next_mstatus, .inject_mepc, .next_mepc,
    .inject_mcause, .next_mcause, .inject_mtval, .next_mtval,
    .inject_mip, .next_mip,
    .mstatus(curr_mstatus), .mtvec(curr_mtvec), .mie(curr_mie), .mip(curr_mip),
    .mscratch, .mepc(curr_mepc), .mcause(curr_mcause), .mtval,
    .mcounteren, .mcountinhibit, .cnt_ifs(cnt_ifs)
  );

  csr_read_mux u_read_mux (
    .csr_addr, .curr_privilege_level, .csr_write, .csr_set, .csr_clear, .mtime,
    .mstatus(curr_mstatus), .mtvec(curr_mtvec), .mie(curr_mie), .mip(curr_mip),
    .mscratch, .mepc(curr_mepc), .mcause(curr_mcause), .mtval,
    .mcounteren, .mcountinhibit, .cnt_ifs(cnt_ifs), .old_csr_val, .invalid_addr
  );

  // Slot 0 counts cycles, slot 1 retired instructions, the rest hpm events
  for (genvar i = 0; i < `CSR_NUM_COUNTERS; i++) begin : g_cnt
    if (i == 0) begin : g_cycle
      assign cnt_ifs[i].inc = 1'b1;
    end else if (i == 1) begin : g_instret
      assign cnt_ifs[i].inc = inst_ret;
    end else begin : g_hpm
      assign cnt_ifs[i].inc = hpm_inc[i-2];
    end
    csr_counter u_counter (.CLK, .nRST, .cif(cnt_ifs[i]));
  end

  assign invalid_csr = invalid_priv | invalid_addr;

endmodule

// ==== src/csr_read_mux.sv ====
// CSR read-back: old-value select, mcounteren gating and unknown-address flag
`include "csr_settings.svh"

module csr_read_mux
  import csr_addr_pkg::*;
  import csr_fields_pkg::*;
(
  input  csr_addr_t                 csr_addr,
  input  priv_level_t               curr_privilege_level,
  input  logic                      csr_write,
  input  logic                      csr_set,
  input  logic                      csr_clear,
  input  logic [`CSR_CNT_WIDTH-1:0] mtime,
  input  mstatus_t                  mstatus,
  input  mtvec_t                    mtvec,
  input  mint_t                     mie,
  input  mint_t                     mip,
  input  csr_word_t                 mscratch,
  input  csr_word_t                 mepc,
  input  mcause_t                   mcause,
  input  csr_word_t                 mtval,
  input  csr_word_t                 mcounteren,
  input  csr_word_t                 mcountinhibit,
  csr_counter_if.rd                 cnt_ifs [`CSR_NUM_COUNTERS],
  output csr_word_t                 old_csr_val,
  output logic                      invalid_addr
);

  logic [`CSR_CNT_WIDTH-1:0] cnt_val [`CSR_NUM_COUNTERS];
  logic      user_mode;
  logic      cnt_lo;
  logic      cnt_hi;
  logic      cnt_user;
  cnt_slot_t slot;
  logic      known;
  logic      gated;

  for (genvar i = 0; i < `CSR_NUM_COUNTERS; i++) begin : g_val
    assign cnt_val[i] = cnt_ifs[i].value;
  end

  assign user_mode = curr_privilege_level != M_MODE;
  assign cnt_user  = csr_addr[11:8] == 4'hC;

  // Find the counter slot behind a machine or user counter address
  always_comb begin
    cnt_lo = 1'b0;
    cnt_hi = 1'b0;
    slot   = '0;
    for (int i = 0; i < `CSR_NUM_COUNTERS; i++) begin
      if (csr_addr == CNT_SLOT_LO_ADDR[i] ||
          csr_addr == CNT_SLOT_LO_ADDR[i] + USER_CNT_OFFSET) begin
        cnt_lo = 1'b1;
        slot   = cnt_slot_t'(i);
      end
      if (csr_addr == CNT_SLOT_HI_ADDR[i] ||
          csr_addr == CNT_SLOT_HI_ADDR[i] + USER_CNT_OFFSET) begin
        cnt_hi = 1'b1;
        slot   = cnt_slot_t'(i);
      end
    end
  end

  always_comb begin
    old_csr_val = '0;
    known       = 1'b1;
    gated       = 1'b0;
    case (csr_addr)
      MVENDORID_ADDR, MARCHID_ADDR, MIMPID_ADDR,
      MCONFIGPTR_ADDR, MSTATUSH_ADDR: old_csr_val = '0;
      MHARTID_ADDR:       old_csr_val = csr_word_t'(`CSR_HART_ID);
      MISA_ADDR:          old_csr_val = MISA_RV32IU;
      MSTATUS_ADDR:       old_csr_val = mstatus;
      MTVEC_ADDR:         old_csr_val = mtvec;
      MIE_ADDR:           old_csr_val = mie;
      MIP_ADDR:           old_csr_val = mip;
      MSCRATCH_ADDR:      old_csr_val = mscratch;
      MEPC_ADDR:          old_csr_val = mepc;
      MCAUSE_ADDR:        old_csr_val = mcause;
      MTVAL_ADDR:         old_csr_val = mtval;
      MCOUNTEREN_ADDR:    old_csr_val = mcounteren;
      MCOUNTINHIBIT_ADDR: old_csr_val = mcountinhibit;
      TIME_ADDR, TIMEH_ADDR: begin
        gated       = user_mode & ~mcounteren[TIME_BIT];
        old_csr_val = csr_addr[7] ? mtime[63:32] : mtime[31:0];
      end
      default: begin
        if (cnt_lo || cnt_hi) begin
          gated       = cnt_user & user_mode & ~mcounteren[CNT_SLOT_BIT[slot]];
          old_csr_val = cnt_hi ? cnt_val[slot][63:32] : cnt_val[slot][31:0];
        end else begin
          known = 1'b0;   // Nothing lives here
        end
      end
    endcase
    if (gated) old_csr_val = '0;  // Hide value from U mode
  end

  assign invalid_addr = gated | (~known & (csr_write | csr_set | csr_clear));

endmodule

// ==== src/csr_settings.svh ====
// Global CSR file settings: data width, counter count, counter width and hart id
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

// Data word width of the core
`define CSR_XLEN 32

// Counter slots: cycle, instret, hpm3, hpm4
`define CSR_NUM_COUNTERS 4

// Full width of each performance counter
`define CSR_CNT_WIDTH 64

// Value read back from mhartid
`define CSR_HART_ID 0

`endif

// ==== src/csr_trap_regs.sv ====
// Machine trap setup and handling registers with WARL legalization and trap injection
`include "csr_settings.svh"

module csr_trap_regs
  import csr_addr_pkg::*;
  import csr_fields_pkg::*;
(
  input  logic        CLK,
  input  logic        nRST,
  input  csr_view_u   merged_val,
  input  csr_word_t   new_csr_val,
  input  logic        we_mstatus,
  input  logic        we_mtvec,
  input  logic        we_mie,
  input  logic        we_mip,
  input  logic        we_mscratch,
  input  logic        we_mepc,
  input  logic        we_mcause,
  input  logic        we_mtval,
  input  logic        we_mcounteren,
  input  logic        we_mcountinhibit,
  input  logic        inject_mstatus,
  input  mstatus_t    next_mstatus,
  input  logic        inject_mepc,
  input  csr_word_t   next_mepc,
  input  logic        inject_mcause,
  input  mcause_t     next_mcause,
  input  logic        inject_mtval,
  input  csr_word_t   next_mtval,
  input  logic        inject_mip,
  input  mint_t       next_mip,
  output mstatus_t    mstatus,
  output mtvec_t      mtvec,
  output mint_t       mie,
  output mint_t       mip,
  output csr_word_t   mscratch,
  output csr_word_t   mepc,
  output mcause_t     mcause,
  output csr_word_t   mtval,
  output csr_word_t   mcounteren,
  output csr_word_t   mcountinhibit,
  csr_counter_if.cfg  cnt_ifs [`CSR_NUM_COUNTERS]
);

  mstatus_t  mstatus_n;
  mtvec_t    mtvec_n;
  mint_t     mie_n;
  mint_t     mip_n;
  csr_word_t mscratch_n;
  csr_word_t mepc_n;
  mcause_t   mcause_n;
  csr_word_t mtval_n;

  // Keep only the machine-level interrupt bits
  function automatic mint_t m_bits_only(mint_t v);
    mint_t r;
    r      = '0;
    r.msie = v.msie;
    r.mtie = v.mtie;
    r.meie = v.meie;
    return r;
  endfunction

  always_comb begin
    mstatus_n  = mstatus;
    mtvec_n    = mtvec;
    mie_n      = mie;
    mip_n      = mip;
    mscratch_n = mscratch;
    mepc_n     = mepc;
    mcause_n   = mcause;
    mtval_n    = mtval;

    if (we_mstatus) begin
      mstatus_n.mie  = merged_val.mstatus.mie;
      mstatus_n.mpie = merged_val.mstatus.mpie;
      mstatus_n.mprv = merged_val.mstatus.mprv;
      mstatus_n.tw   = merged_val.mstatus.tw;
      // S and reserved fold to U
      mstatus_n.mpp  = (merged_val.mstatus.mpp == M_MODE) ? M_MODE : U_MODE;
    end
    if (we_mtvec) begin
      mtvec_n.base = merged_val.mtvec.base;
      mtvec_n.mode = (new_csr_val[1:0] > 2'b01) ? DIRECT : merged_val.mtvec.mode;
    end
    if (we_mie)      mie_n      = m_bits_only(merged_val.mint);
    if (we_mip)      mip_n      = m_bits_only(merged_val.mint);
    if (we_mscratch) mscratch_n = merged_val.word;
    if (we_mepc)     mepc_n     = merged_val.word;
    if (we_mcause)   mcause_n   = merged_val.mcause;
    if (we_mtval)    mtval_n    = merged_val.word;

    // Trap handler wins over the CSR instruction
    if (inject_mstatus) mstatus_n = next_mstatus;
    if (inject_mepc)    mepc_n    = next_mepc;
    if (inject_mcause)  mcause_n  = next_mcause;
    if (inject_mtval)   mtval_n   = next_mtval;
    if (inject_mip)     mip_n     = next_mip;

    mstatus_n.sd = (&mstatus_n.fs) | (&mstatus_n.vs) | (&mstatus_n.xs);
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mstatus       <= '0;
      mstatus.tw    <= 1'b1;
      mstatus.mpp   <= U_MODE;
      mtvec         <= '0;
      mie           <= '0;
      mip           <= '0;
      mscratch      <= '0;
      mepc          <= '0;
      mcause        <= '0;
      mtval         <= '0;
      mcounteren    <= '1;   // All counters visible to U mode
      mcountinhibit <= '0;
    end else begin
      mstatus  <= mstatus_n;
      mtvec    <= mtvec_n;
      mie      <= mie_n;
      mip      <= mip_n;
      mscratch <= mscratch_n;
      mepc     <= mepc_n;
      mcause   <= mcause_n;
      mtval    <= mtval_n;
      if (we_mcounteren)    mcounteren    <= merged_val.word;
      if (we_mcountinhibit) mcountinhibit <= merged_val.word;
    end
  end

  for (genvar i = 0; i < `CSR_NUM_COUNTERS; i++) begin : g_inhibit
    assign cnt_ifs[i].inhibit = mcountinhibit[CNT_SLOT_BIT[i]];
  end

  a_mtvec_mode: assert property (@(posedge CLK) disable iff (!nRST)
    mtvec.mode <= VECTORED)
    else $error("csr_trap_regs: illegal mtvec mode %0d", mtvec.mode);

endmodule

// ==== tb.f ====
+incdir+src
src/csr_addr_pkg.sv
src/csr_fields_pkg.sv
src/csr_counter_if.sv
src/csr_access_decode.sv
src/csr_counter.sv
src/csr_trap_regs.sv
src/csr_read_mux.sv
src/csr_file.sv
tb/tb_csr_file.sv

// ==== tb/tb_csr_file.sv ====
// Testbench for the CSR file: clock, reset, stimulus table, counter model, checks, timeout
`include "csr_settings.svh"

module tb_csr_file
  import csr_addr_pkg::*;
  import csr_fields_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_ROWS    = 54;
  localparam int CYCLE_LIMIT = NUM_ROWS + 8 + 50;
  localparam logic [63:0] MTIME_VAL = 64'h0000_00C3_8765_4321;

  localparam logic [1:0] OP_NO  = 2'd0;
  localparam logic [1:0] OP_WR  = 2'd1;
  localparam logic [1:0] OP_SET = 2'd2;
  localparam logic [1:0] OP_CLR = 2'd3;

  // Where the expected read value comes from
  localparam logic [1:0] SRC_TAB  = 2'd0;
  localparam logic [1:0] SRC_CNT  = 2'd1;   // Counter model
  localparam logic [1:0] SRC_TIME = 2'd2;

  // Injection mask bits: mstatus, mepc, mcause
  localparam logic [2:0] INJ_NO    = 3'b000;
  localparam logic [2:0] INJ_ST    = 3'b100;
  localparam logic [2:0] INJ_EPC   = 3'b010;
  localparam logic [2:0] INJ_CAUSE = 3'b001;

  typedef struct packed {
    logic [1:0]  op;
    logic [11:0] addr;
    logic [31:0] data;
    priv_level_t priv;
    logic [2:0]  inj;
    logic [31:0] inj_val;
    logic [1:0]  src;
    logic [31:0] exp_old;
    logic        exp_inv;
  } row_t;

  logic CLK = 1'b0;
  logic nRST;
  logic [63:0] mtime;
  csr_addr_t csr_addr;
  logic csr_write, csr_set, csr_clear, csr_read_only, valid_write;
  csr_word_t new_csr_val;
  priv_level_t curr_privilege_level;
  logic inst_ret;
  logic [1:0] hpm_inc;
  logic inject_mstatus, inject_mepc, inject_mcause, inject_mtval, inject_mip;
  mstatus_t next_mstatus;
  csr_word_t next_mepc, next_mtval;
  mcause_t next_mcause;
  mint_t next_mip;
  csr_word_t old_csr_val;
  logic invalid_csr;
  mstatus_t curr_mstatus;
  mtvec_t curr_mtvec;
  mint_t curr_mie, curr_mip;
  csr_word_t curr_mepc;
  mcause_t curr_mcause;

  row_t rows [NUM_ROWS];
  logic [63:0] ref_cnt [`CSR_NUM_COUNTERS];
  logic [31:0] ref_inh;
  integer seed = 32'hf971;
  int cycles = 0;

  csr_file dut (.*);

  always #4 CLK = ~CLK;

  always @(posedge CLK) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: the stimulus table did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TB FAILED");
      $fatal(1);
    end
  end

  task automatic load_table();
    // Read, write, set and clear on mscratch and mepc
    rows[0]  = '{OP_WR,  12'h340, 32'hA5A5_0F0F, M_MODE, INJ_NO, 32'h0, SRC_TAB, 32'h0, 1'b0};
    rows[1]  = '{OP_SET, 12'h340, 32'h0000_F0F0, M_MODE, INJ_NO, 32'h0, SRC_TAB, 32'hA5A5_0F0F, 1'b0};
    rows[2]  = '{OP_CLR, 12'h340, 32'hA5A5_0000, M_MODE, INJ_NO, 32'h0, SRC_TAB, 32'hA5A5_FFFF, 1'b0};
    rows[3]  = '{OP_NO,  12'h340, 32'h0, M_MODE, INJ_NO, 32'h0, SRC_TAB, 32'h0000_FFFF, 1'b0};
    rows[4]  = '{OP_WR,  12'h341, 32'h1234_5678, M_MODE, INJ_NO, 32'h0, SRC_TAB, 32'h0, 1'b0};
    rows[5]  = '{OP_SET, 12'h341, 32'h0000_0003, M_MODE, INJ_NO, 32'h0, SRC_TAB, 32'h1234_5678, 1'b0};
    rows[6]  = '{OP_CLR, 12'h341, 32'h1200_0000, M_MODE, INJ_NO, 32'h0, SRC_TAB, 32'h1234_567B, 1'b0};
    rows[7]  = '{OP_NO,  12'h341, 32'h0, M_MODE, INJ_NO, 32'h0, SRC_TAB, 32'h0034_567B, 1'b0};
    // WARL fields: mpp, mtvec mode, S interrupt bits
    rows[8]  = '{OP_WR,  12'h300, 32'h0000_0800, M_MODE, INJ_NO, 32'h0, SRC_TAB, 32'h0020_0000, 1'b0};
    rows[9]  = '{OP_WR,  12'h300, 32'h0000_1808, M_MODE, INJ_NO, 32'h0, SRC_TAB, 32'h0, 1'b0};
    rows[10] = '{OP_WR,  12'h300, 32'h0000_1000, M_MODE, INJ_NO, 32'h0, SRC_TAB, 32'h0000_1808, 1'b0};
    rows[11] = '{OP_NO,  12'h300, 32'h0, M_MODE, INJ_NO, 32'h0, SRC_TAB, 32'h0, 1'b0};
    rows[12] = '{OP_WR,  12'h305, 32'h8000_0102, M_MODE, INJ_NO, 32'h0, SRC_TAB, 32'h0, 1'b0};
    rows[13] = '{OP_WR,  12'h305, 32'h8000_0201, M_MODE, INJ_NO, 32'h0, SRC_TAB, 32'h8000_0100, 1'b0};
    rows[14] = '{OP_WR,  12'h305, 32'h0000_0043, M_MODE, INJ_NO, 32'h0, SRC_TAB, 32'h8000_0201, 1'b0};
    rows[15] = '{OP_NO,  12'h305, 32'h0, M_MODE, INJ_NO, 32'h0, SRC_TAB, 32'h0000_0040, 1'b0};
    rows[16] = '{OP_WR,  12'h304, 32'h0000_0AAA, M_MODE, INJ_NO, 32'h0, SRC_TAB, 32'h0, 1'b0};
    rows[17] = '{OP_NO,  12'h304, 32'h0, M_MODE, INJ_NO, 32'h0, SRC_TAB, 32'h0000_0888, 1'b0};
    rows[18] = '{OP_WR,  12'h344, 32'h0000_0FFF, M_MODE, INJ_NO, 32'h0, SRC_TAB, 32'h0, 1'b0};
    rows[19] = '{OP_NO,  12'h344, 32'h0, M_MODE, INJ_NO, 32'h0, SRC_TAB, 32'h0000_0888, 1'b0};
    // Privilege, read-only and unknown address
    rows[20] = '{OP_WR,  12'h340, 32'hDEAD_BEEF, U_MODE, INJ_NO, 32'h0, SRC_TAB, 32'h0000_FFFF, 1'b1};
    rows[21] = '{OP_NO,  12'h340, 32'h0, M_MODE, INJ_NO, 32'h0, SRC_TAB, 32'h0000_FFFF, 1'b0};
    rows[22] = '{OP_WR,  12'hF14, 32'h0000_0001, M_MODE, INJ_NO, 32'h0, SRC_TAB, 32'h0, 1'b1};
    rows[23] = '{OP_SET, 12'h7C0, 32'h0000_0001, M_MODE, INJ_NO, 32'h0, SRC_TAB, 32'h0, 1'b1};
    rows[24] = '{OP_NO,  12'hF14, 32'h0, M_MODE, INJ_NO, 32'h0, SRC_TAB, `CSR_HART_ID, 1'b0};
    rows[25] = '{OP_NO,  12'h301, 32'h0, M_MODE, INJ_NO, 32'h0, SRC_TAB, 32'h4010_0100, 1'b0};
    // Counters, inhibit and U-mode gating
    rows[26] = '{OP_WR,  12'hB00, 32'h0000_0100, M_MODE, INJ_NO, 32'h0, SRC_CNT, 32'h0, 1'b0};
    rows[27] = '{OP_NO,  12'hB00, 32'h0, M_MODE, INJ_NO, 32'h0, SRC_CNT, 32'h0, 1'b0};
    rows[28] = '{OP_NO,  12'hB00, 32'h0, M_MODE, INJ_NO, 32'h0, SRC_CNT, 32'h0, 1'b0};
    rows[29] = '{OP_WR,  12'hB80, 32'h0000_0001, M_MODE, INJ_NO, 32'h0, SRC_CNT, 32'h0, 1'b0};
    rows[30] = '{OP_NO,  12'hB80, 32'h0, M_MODE, INJ_NO, 32'h0, SRC_CNT, 32'h0, 1'b0};
    rows[31] = '{OP_WR,  12'h320, 32'h0000_0001, M_MODE, INJ_NO, 32'h0, SRC_TAB, 32'h0, 1'b0};
    rows[32] = '{OP_NO,  12'hB00, 32'h0, M_MODE, INJ_NO, 32'h0, SRC_CNT, 32'h0, 1'b0};
    rows[33] = '{OP_NO,  12'hB00, 32'h0, M_MODE, INJ_NO, 32'h0, SRC_CNT, 32'h0, 1'b0};
    rows[34] = '{OP_WR,  12'h320, 32'h0, M_MODE, INJ_NO, 32'h0, SRC_TAB, 32'h0000_0001, 1'b0};
    rows[35] = '{OP_NO,  12'hB02, 32'h0, M_MODE, INJ_NO, 32'h0, SRC_CNT, 32'h0, 1'b0};
    rows[36] = '{OP_NO,  12'hB03, 32'h0, M_MODE, INJ_NO, 32'h0, SRC_CNT, 32'h0, 1'b0};
    rows[37] = '{OP_NO,  12'hB04, 32'h0, M_MODE, INJ_NO, 32'h0, SRC_CNT, 32'h0, 1'b0};
    rows[38] = '{OP_WR,  12'hB83, 32'h0000_0005, M_MODE, INJ_NO, 32'h0, SRC_CNT, 32'h0, 1'b0};
    rows[39] = '{OP_NO,  12'hB83, 32'h0, M_MODE, INJ_NO, 32'h0, SRC_CNT, 32'h0, 1'b0};
    rows[40] = '{OP_NO,  12'hC03, 32'h0, M_MODE, INJ_NO, 32'h0, SRC_CNT, 32'h0, 1'b0};
    rows[41] = '{OP_WR,  12'h306, 32'hFFFF_FFFC, M_MODE, INJ_NO, 32'h0, SRC_TAB, 32'hFFFF_FFFF, 1'b0};
    rows[42] = '{OP_NO,  12'hC00, 32'h0, U_MODE, INJ_NO, 32'h0, SRC_TAB, 32'h0, 1'b1};
    rows[43] = '{OP_NO,  12'hC01, 32'h0, U_MODE, INJ_NO, 32'h0, SRC_TAB, 32'h0, 1'b1};
    rows[44] = '{OP_NO,  12'hC02, 32'h0, U_MODE, INJ_NO, 32'h0, SRC_CNT, 32'h0, 1'b0};
    rows[45] = '{OP_SET, 12'h306, 32'h0000_0002, M_MODE, INJ_NO, 32'h0, SRC_TAB, 32'hFFFF_FFFC, 1'b0};
    rows[46] = '{OP_NO,  12'hC01, 32'h0, U_MODE, INJ_NO, 32'h0, SRC_TIME, 32'h0, 1'b0};
    rows[47] = '{OP_NO,  12'hC81, 32'h0, U_MODE, INJ_NO, 32'h0, SRC_TIME, 32'h0, 1'b0};
    // Trap injection beats a same-cycle write
    rows[48] = '{OP_WR,  12'h341, 32'h1111_1111, M_MODE, INJ_EPC, 32'h8000_0040, SRC_TAB,
                 32'h0034_567B, 1'b0};
    rows[49] = '{OP_NO,  12'h341, 32'h0, M_MODE, INJ_NO, 32'h0, SRC_TAB, 32'h8000_0040, 1'b0};
    rows[50] = '{OP_WR,  12'h342, 32'h0000_0002, M_MODE, INJ_CAUSE, 32'h8000_0007, SRC_TAB,
                 32'h0, 1'b0};
    rows[51] = '{OP_NO,  12'h342, 32'h0, M_MODE, INJ_NO, 32'h0, SRC_TAB, 32'h8000_0007, 1'b0};
    rows[52] = '{OP_WR,  12'h300, 32'h0000_1808, M_MODE, INJ_ST, 32'h0000_6088, SRC_TAB,
                 32'h0, 1'b0};
    rows[53] = '{OP_NO,  12'h300, 32'h0, M_MODE, INJ_NO, 32'h0, SRC_TAB, 32'h8000_6088, 1'b0};
  endtask

  task automatic apply_row(input row_t r);
    int rnd;
    rnd                  = $random(seed);
    csr_addr             = r.addr;
    csr_write            = (r.op == OP_WR);
    csr_set              = (r.op == OP_SET);
    csr_clear            = (r.op == OP_CLR);
    csr_read_only        = (r.op == OP_NO);
    valid_write          = (r.op != OP_NO);
    new_csr_val          = r.data;
    curr_privilege_level = r.priv;
    inject_mstatus       = r.inj[2];
    inject_mepc          = r.inj[1];
    inject_mcause        = r.inj[0];
    next_mstatus         = mstatus_t'(r.inj_val);
    next_mepc            = r.inj_val;
    next_mcause          = mcause_t'(r.inj_val);
    inst_ret             = rnd[0];    // Random retire and hpm events
    hpm_inc              = rnd[2:1];
  endtask

  function automatic logic [31:0] merge(input logic [31:0] old_v, input logic [31:0] new_v);
    if (csr_set) return old_v | new_v;
    if (csr_clear) return old_v & ~new_v;
    return new_v;
  endfunction

  // Counter model, advanced once per clock from the inputs of that cycle
  task automatic model_step();
    logic wr_ok;
    logic inc;
    wr_ok = (csr_write | csr_set | csr_clear) && valid_write && curr_privilege_level == M_MODE;
    for (int i = 0; i < `CSR_NUM_COUNTERS; i++) begin
      inc = (i == 0) ? 1'b1 : (i == 1) ? inst_ret : hpm_inc[i-2];
      if (wr_ok && csr_addr == CNT_SLOT_LO_ADDR[i]) begin
        ref_cnt[i][31:0] = merge(ref_cnt[i][31:0], new_csr_val);
      end else if (wr_ok && csr_addr == CNT_SLOT_HI_ADDR[i]) begin
        ref_cnt[i][63:32] = merge(ref_cnt[i][63:32], new_csr_val);
      end else if (!ref_inh[CNT_SLOT_BIT[i]]) begin
        ref_cnt[i] = ref_cnt[i] + 64'(inc);
      end
    end
    if (wr_ok && csr_addr == MCOUNTINHIBIT_ADDR) ref_inh = merge(ref_inh, new_csr_val);
  endtask

  // Machine or user view of a counter half
  function automatic logic [31:0] counter_half(input csr_addr_t a);
    for (int i = 0; i < `CSR_NUM_COUNTERS; i++) begin
      if (a == CNT_SLOT_LO_ADDR[i] || a == CNT_SLOT_LO_ADDR[i] + 12'h100) return ref_cnt[i][31:0];
      if (a == CNT_SLOT_HI_ADDR[i] || a == CNT_SLOT_HI_ADDR[i] + 12'h100) return ref_cnt[i][63:32];
    end
    return 32'h0;
  endfunction

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_row(input row_t r);
    logic [31:0] exp;
    case (r.src)
      SRC_CNT:  exp = counter_half(r.addr);
      SRC_TIME: exp = (r.addr == TIMEH_ADDR) ? MTIME_VAL[63:32] : MTIME_VAL[31:0];
      default:  exp = r.exp_old;
    endcase
    check_word("old_csr_val", old_csr_val, exp);
    check_word("invalid_csr", 32'(invalid_csr), 32'(r.exp_inv));
    if (r.addr == MSTATUS_ADDR) check_word("curr_mstatus", curr_mstatus, exp);
    if (r.addr == MTVEC_ADDR) check_word("curr_mtvec", curr_mtvec, exp);
    if (r.addr == MIE_ADDR) check_word("curr_mie", curr_mie, exp);
    if (r.addr == MIP_ADDR) check_word("curr_mip", curr_mip, exp);
    if (r.addr == MEPC_ADDR) check_word("curr_mepc", curr_mepc, exp);
    if (r.addr == MCAUSE_ADDR) check_word("curr_mcause", curr_mcause, exp);
  endtask

  initial begin
    nRST = 1'b0;
    mtime = MTIME_VAL;
    apply_row('{OP_NO, 12'h0, 32'h0, M_MODE, INJ_NO, 32'h0, SRC_TAB, 32'h0, 1'b0});
    inst_ret = 1'b0;
    hpm_inc = 2'b00;
    inject_mtval = 1'b0;
    inject_mip = 1'b0;
    next_mtval = '0;
    next_mip = '0;
    ref_inh = '0;
    for (int i = 0; i < `CSR_NUM_COUNTERS; i++) ref_cnt[i] = '0;
    load_table();
    repeat (8) @(posedge CLK);
    #1 nRST = 1'b1;
    #6 model_step();    // Idle cycle before the first row
    for (int r = 0; r < NUM_ROWS; r++) begin
      @(posedge CLK);
      #1 apply_row(rows[r]);
      #6 check_row(rows[r]);
      model_step();
    end
    $display("TB PASSED");
    $finish;
  end

endmodule
